/* logic/spi_params.svh */
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// full command word, direction bit first
`define SPI_CMD_WIDTH 12

// byte returned by a read frame
`define SPI_READ_WIDTH 8

`define SPI_ADDR_WIDTH 3

// clk cycles per sclk half period
`define SPI_HALF_DIV 4

// direction bit plus address, sent ahead of the read phase
`define SPI_RD_HDR_BITS 4

`endif

/* logic/spi_pkg.sv */
`default_nettype none

`include "spi_params.svh"

package spi_pkg;

  // field order follows command bits 11 down to 0
  typedef struct packed {
    logic                         write;
    logic [`SPI_ADDR_WIDTH-1:0]   addr;
    logic [`SPI_READ_WIDTH-1:0]   wdata;
  } spi_cmd_t;

  // transfer descriptor handed from decode to the shift engine
  typedef struct packed {
    logic [`SPI_CMD_WIDTH-1:0]    tx_word;
    logic [3:0]                   tx_bits;
    logic [3:0]                   rx_bits;
    logic                         is_read;
    logic                         pad;
  } spi_xfer_t;

endpackage

`default_nettype wire

/* logic/spi_cmd_decode.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_params.svh"

module spi_cmd_decode (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire spi_pkg::spi_cmd_t cmd_in,
  input  wire                 cmd_vld,
  output logic                cmd_rdy,
  output spi_pkg::spi_xfer_t  xfer,
  output logic                xfer_start,
  input  wire                 xfer_done
);

  import spi_pkg::*;

  logic      busy;
  logic      accept;
  spi_xfer_t xfer_next;

  // a strobe while a frame is pending or running is simply dropped
  assign accept  = cmd_vld && !busy;
  assign cmd_rdy = !busy;

  always_comb
  begin
    xfer_next         = '0;
    xfer_next.is_read = !cmd_in.write;
    if (cmd_in.write)
    begin
      xfer_next.tx_word = cmd_in;
      xfer_next.tx_bits = 4'(`SPI_CMD_WIDTH);
      xfer_next.rx_bits = 4'd0;
    end
    else
    begin
      // only the header goes out, the data byte slot stays zero
      xfer_next.tx_word = {cmd_in.write, cmd_in.addr,
                           {(`SPI_CMD_WIDTH - `SPI_RD_HDR_BITS){1'b0}}};
      xfer_next.tx_bits = 4'(`SPI_RD_HDR_BITS);
      xfer_next.rx_bits = 4'(`SPI_READ_WIDTH);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy       <= 1'b0;
      xfer_start <= 1'b0;
    end
    else
    begin
      xfer_start <= accept;
      if (accept)
        busy <= 1'b1;
      else if (xfer_done)
        busy <= 1'b0;
    end
  end

  // descriptor stays stable for the whole frame since busy blocks new commands
  always_ff @(posedge clk)
  begin
    if (accept)
      xfer <= xfer_next;
  end

endmodule

`default_nettype wire

/* logic/spi_shift_engine.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_params.svh"

module spi_shift_engine (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire spi_pkg::spi_xfer_t xfer,
  input  wire                 xfer_start,
  output logic                xfer_done,
  output logic                sclk,
  output logic                cs,
  output logic                mosi,
  input  wire                 miso,
  output logic                rx_sample,
  output logic                rx_bit,
  output logic                frame_end
);

  localparam int cmd_w = `SPI_CMD_WIDTH;
  localparam int div_w = (`SPI_HALF_DIV > 1) ? $clog2(`SPI_HALF_DIV) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(`SPI_HALF_DIV - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_finish
  } state_t;

  state_t           state;
  logic [div_w-1:0] div_cnt;
  logic             div_wrap;
  logic [4:0]       bit_cnt;
  logic [4:0]       bit_next;
  logic [4:0]       tx_bits_ext;
  logic [4:0]       total_bits;
  logic [cmd_w-1:0] shreg;

  assign div_wrap    = (div_cnt == div_last);
  assign bit_next    = bit_cnt + 5'd1;
  assign tx_bits_ext = {1'b0, xfer.tx_bits};
  assign total_bits  = {1'b0, xfer.tx_bits} + {1'b0, xfer.rx_bits};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= st_idle;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      sclk      <= 1'b0;
      cs        <= 1'b1;
      mosi      <= 1'b0;
      rx_sample <= 1'b0;
      rx_bit    <= 1'b0;
      frame_end <= 1'b0;
      xfer_done <= 1'b0;
    end
    else
    begin
      rx_sample <= 1'b0;
      frame_end <= 1'b0;
      xfer_done <= 1'b0;
      case (state)
        st_idle:
        begin
          if (xfer_start)
          begin
            state   <= st_shift;
            cs      <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            mosi    <= xfer.tx_word[cmd_w-1];
          end
        end
        st_shift:
        begin
          if (div_wrap)
          begin
            div_cnt <= '0;
            sclk    <= !sclk;
            if (!sclk)
            begin
              // rising edge, miso is stable here in mode 0
              if (xfer.is_read && bit_cnt >= tx_bits_ext)
              begin
                rx_sample <= 1'b1;
                rx_bit    <= miso;
              end
            end
            else
            begin
              bit_cnt <= bit_next;
              if (bit_next == total_bits)
              begin
                state <= st_finish;
                mosi  <= 1'b0;
              end
              else if (bit_next < tx_bits_ext)
                mosi <= shreg[cmd_w-1];
              else
                mosi <= 1'b0;
            end
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        st_finish:
        begin
          // cs trails the last falling edge by one half period
          if (div_wrap)
          begin
            state     <= st_idle;
            cs        <= 1'b1;
            div_cnt   <= '0;
            frame_end <= 1'b1;
            xfer_done <= 1'b1;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // top bit of shreg is always the next mosi bit
  always_ff @(posedge clk)
  begin
    if (state == st_idle && xfer_start)
      shreg <= xfer.tx_word << 1;
    else if (state == st_shift && div_wrap && sclk)
      shreg <= shreg << 1;
  end

endmodule

`default_nettype wire

/* logic/spi_read_capture.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_params.svh"

module spi_read_capture (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         rx_sample,
  input  wire                         rx_bit,
  input  wire                         frame_end,
  output logic                        read_vld,
  output logic [`SPI_READ_WIDTH-1:0]  read_data
);

  localparam int rd_w  = `SPI_READ_WIDTH;
  localparam int cnt_w = $clog2(`SPI_READ_WIDTH + 1);

  logic [rd_w-1:0]  rx_shift;
  logic [cnt_w-1:0] rx_cnt;

  // msb arrives first, so shift toward the top
  always_ff @(posedge clk)
  begin
    if (rx_sample)
      rx_shift <= {rx_shift[rd_w-2:0], rx_bit};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_cnt    <= '0;
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= 1'b0;
      if (frame_end)
      begin
        rx_cnt <= '0;
        // a write frame ends with no samples and leaves read_data alone
        if (rx_cnt == cnt_w'(rd_w))
        begin
          read_data <= rx_shift;
          read_vld  <= 1'b1;
        end
      end
      else if (rx_sample)
        rx_cnt <= rx_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/spi_cmd_master.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_params.svh"

module spi_cmd_master (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire spi_pkg::spi_cmd_t      cmd_in,
  input  wire                         cmd_vld,
  output logic                        cmd_rdy,
  output logic                        sclk,
  output logic                        cs,
  output logic                        mosi,
  input  wire                         miso,
  output logic                        read_vld,
  output logic [`SPI_READ_WIDTH-1:0]  read_data
);

  import spi_pkg::*;

  spi_xfer_t xfer;
  logic      xfer_start;
  logic      xfer_done;
  logic      rx_sample;
  logic      rx_bit;
  logic      frame_end;

  spi_cmd_decode decode_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .xfer       (xfer),
    .xfer_start (xfer_start),
    .xfer_done  (xfer_done)
  );

  spi_shift_engine engine_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .xfer       (xfer),
    .xfer_start (xfer_start),
    .xfer_done  (xfer_done),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .rx_sample  (rx_sample),
    .rx_bit     (rx_bit),
    .frame_end  (frame_end)
  );

  // read result appears one cycle after cs rises
  spi_read_capture capture_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_sample  (rx_sample),
    .rx_bit     (rx_bit),
    .frame_end  (frame_end),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

endmodule

`default_nettype wire

/* dv/spi_cmd_master_assertions.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_cmd_master_assertions (
  input wire clk,
  input wire rst_n,
  input wire sclk,
  input wire cs,
  input wire cmd_rdy,
  input wire read_vld
);

  // mode 0 parks sclk low whenever the slave is deselected
  sclk_idle_low: assert property (
    @(posedge clk) disable iff (!rst_n)
    cs |-> !sclk
  )
  else $error("sclk high while cs is deasserted");

  // no command can be taken while a frame is on the wire
  busy_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    !cs |-> !cmd_rdy
  )
  else $error("cmd_rdy high while cs is asserted");

  read_vld_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld
  )
  else $error("read_vld held for two cycles");

endmodule

bind spi_cmd_master spi_cmd_master_assertions assertions_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .sclk     (sclk),
  .cs       (cs),
  .cmd_rdy  (cmd_rdy),
  .read_vld (read_vld)
);

`default_nettype wire

/* dv/spi_cmd_master_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_params.svh"

module spi_cmd_master_tb;

  import spi_pkg::*;

  localparam int clk_period  = 4;
  localparam int timeout_cyc = 200;
  localparam int num_entries = 13;
  localparam int num_regs    = 1 << `SPI_ADDR_WIDTH;

  // selects the dut output that a wait loop watches
  localparam int sig_cs       = 0;
  localparam int sig_cmd_rdy  = 1;
  localparam int sig_read_vld = 2;

  typedef struct packed {
    spi_cmd_t                   cmd;
    logic                       has_read;
    logic [`SPI_READ_WIDTH-1:0] exp_byte;
    logic                       strobe_again;
  } entry_t;

  logic                       clk;
  logic                       rst_n;
  spi_cmd_t                   cmd_in;
  logic                       cmd_vld;
  logic                       cmd_rdy;
  logic                       sclk;
  logic                       cs;
  logic                       mosi;
  logic                       miso = 1'b0;
  logic                       read_vld;
  logic [`SPI_READ_WIDTH-1:0] read_data;

  entry_t                     cmd_table [num_entries];
  spi_cmd_t                   junk_cmd;
  logic [7:0]                 init_regs [num_regs];
  logic [7:0]                 slave_regs [num_regs];
  logic [7:0]                 ref_regs [num_regs];

  // slave model state, updated on the clk edge after each sclk or cs change
  logic                       s_sclk;
  logic                       s_cs;
  logic [`SPI_CMD_WIDTH-1:0]  rx_word;
  logic [`SPI_CMD_WIDTH-1:0]  last_word;
  logic [`SPI_ADDR_WIDTH-1:0] rd_addr;
  logic                       rd_active;
  int                         rise_cnt;
  int                         last_rises;
  int                         frame_cnt;
  int                         miso_idx;

  // sclk interval and read_vld monitor state
  logic                       m_sclk;
  logic                       m_cs;
  int                         run_len;
  int                         vld_cnt;

  spi_cmd_master dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic halt_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_value(input string msg);
    halt_run($sformatf("FAIL at %0d ns: %s", $time, msg));
  endtask

  function automatic logic watched(input int which);
    case (which)
      sig_cs:      watched = cs;
      sig_cmd_rdy: watched = cmd_rdy;
      default:     watched = read_vld;
    endcase
  endfunction

  task automatic wait_level(input int which, input logic level, input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (watched(which) !== level && waited < timeout_cyc)
    begin
      @(negedge clk);
      waited++;
    end
    if (watched(which) !== level)
      halt_run($sformatf("timeout: %s never came within %0d cycles", what, timeout_cyc));
  endtask

  // slave model, mode 0: mosi taken at sclk rise, miso moved after sclk fall
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < num_regs; i++)
        slave_regs[i] = init_regs[i];
      miso      <= 1'b0;
      s_sclk    = 1'b0;
      s_cs      = 1'b1;
      rx_word   = '0;
      rd_active = 1'b0;
      rise_cnt  = 0;
      frame_cnt = 0;
    end
    else
    begin
      if (s_cs && !cs)
      begin
        rise_cnt  = 0;
        rx_word   = '0;
        rd_active = 1'b0;
      end
      if (!cs && sclk && !s_sclk)
      begin
        rx_word = {rx_word[`SPI_CMD_WIDTH-2:0], mosi};
        rise_cnt++;
        if (rise_cnt == `SPI_RD_HDR_BITS && !rx_word[`SPI_RD_HDR_BITS-1])
        begin
          rd_active = 1'b1;
          rd_addr   = rx_word[`SPI_ADDR_WIDTH-1:0];
        end
      end
      if (!cs && !sclk && s_sclk && rd_active && rise_cnt < `SPI_CMD_WIDTH)
      begin
        miso_idx = `SPI_CMD_WIDTH - 1 - rise_cnt;
        miso <= slave_regs[rd_addr][miso_idx];
      end
      if (!s_cs && cs)
      begin
        frame_cnt++;
        last_rises = rise_cnt;
        last_word  = rx_word;
        rd_active  = 1'b0;
        miso <= 1'b0;
        if (rise_cnt == `SPI_CMD_WIDTH && rx_word[`SPI_CMD_WIDTH-1])
          slave_regs[rx_word[10:8]] = rx_word[7:0];
      end
      s_sclk = sclk;
      s_cs   = cs;
    end
  end

  // every sclk half inside a frame, and the trailing cs hold, is SPI_HALF_DIV cycles
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      m_sclk  = 1'b0;
      m_cs    = 1'b1;
      run_len = 0;
      vld_cnt = 0;
    end
    else
    begin
      if (read_vld)
        vld_cnt++;
      if (sclk !== m_sclk || cs !== m_cs)
      begin
        if (!m_cs)
          assert (run_len == `SPI_HALF_DIV)
          else fail_value($sformatf("sclk interval of %0d cycles", run_len));
        run_len = 1;
      end
      else
        run_len++;
      m_sclk = sclk;
      m_cs   = cs;
    end
  end

  task automatic set_entry(input int idx, input logic wr, input logic [2:0] addr,
                           input logic [7:0] data, input logic again);
    cmd_table[idx].cmd.write    = wr;
    cmd_table[idx].cmd.addr     = addr;
    cmd_table[idx].cmd.wdata    = data;
    cmd_table[idx].strobe_again = again;
  endtask

  task automatic build_table();
    set_entry(0, 1'b1, 3'd2, 8'hA5, 1'b0);
    set_entry(1, 1'b0, 3'd2, 8'h00, 1'b0);
    set_entry(2, 1'b0, 3'd5, 8'h00, 1'b0);
    set_entry(3, 1'b1, 3'd7, 8'h3C, 1'b1);
    set_entry(4, 1'b0, 3'd7, 8'h00, 1'b1);
    set_entry(5, 1'b1, 3'd0, 8'hFF, 1'b0);
    set_entry(6, 1'b0, 3'd0, 8'h00, 1'b0);
    set_entry(7, 1'b0, 3'd1, 8'h00, 1'b0);
    set_entry(8, 1'b1, 3'd2, 8'h00, 1'b0);
    set_entry(9, 1'b0, 3'd2, 8'h00, 1'b0);
    set_entry(10, 1'b1, 3'd5, 8'h81, 1'b1);
    set_entry(11, 1'b0, 3'd5, 8'h00, 1'b0);
    // address 3 is only ever the target of the ignored strobes
    set_entry(12, 1'b0, 3'd3, 8'h00, 1'b0);
    for (int i = 0; i < num_regs; i++)
      ref_regs[i] = init_regs[i];
    for (int i = 0; i < num_entries; i++)
    begin
      cmd_table[i].has_read = !cmd_table[i].cmd.write;
      cmd_table[i].exp_byte = ref_regs[cmd_table[i].cmd.addr];
      if (cmd_table[i].cmd.write)
        ref_regs[cmd_table[i].cmd.addr] = cmd_table[i].cmd.wdata;
    end
  endtask

  task automatic send_cmd(input spi_cmd_t cmd);
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic run_entry(input int idx);
    entry_t   e;
    spi_cmd_t exp_word;
    int       vld_before;
    e          = cmd_table[idx];
    exp_word   = e.cmd;
    if (!e.cmd.write)
      exp_word.wdata = '0;
    wait_level(sig_cmd_rdy, 1'b1, "cmd_rdy before a command");
    vld_before = vld_cnt;
    send_cmd(e.cmd);
    wait_level(sig_cs, 1'b0, "cs falling at frame start");
    if (e.strobe_again)
    begin
      repeat (20) @(negedge clk);
      assert (cmd_rdy === 1'b0)
      else fail_value($sformatf("entry %0d cmd_rdy high mid-frame", idx));
      send_cmd(junk_cmd);
    end
    wait_level(sig_cs, 1'b1, "cs rising at frame end");
    if (e.has_read)
    begin
      wait_level(sig_read_vld, 1'b1, "read_vld after a read frame");
      assert (read_data === e.exp_byte)
      else fail_value($sformatf("entry %0d read_data %h, expected %h",
                                idx, read_data, e.exp_byte));
    end
    wait_level(sig_cmd_rdy, 1'b1, "cmd_rdy after the frame");
    repeat (3) @(negedge clk);
    assert (frame_cnt == idx + 1)
    else fail_value($sformatf("entry %0d frame count %0d, expected %0d",
                              idx, frame_cnt, idx + 1));
    assert (last_rises == `SPI_CMD_WIDTH)
    else fail_value($sformatf("entry %0d saw %0d sclk rises", idx, last_rises));
    assert (last_word === exp_word)
    else fail_value($sformatf("entry %0d mosi word %h, expected %h",
                              idx, last_word, exp_word));
    assert (vld_cnt - vld_before == int'(e.has_read))
    else fail_value($sformatf("entry %0d gave %0d read_vld pulses",
                              idx, vld_cnt - vld_before));
  endtask

  initial
  begin
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    void'($urandom(32'h73ee));
    for (int i = 0; i < num_regs; i++)
      init_regs[i] = 8'($urandom());
    junk_cmd.write = 1'b1;
    junk_cmd.addr  = 3'd3;
    junk_cmd.wdata = ~init_regs[3];
    build_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (cs === 1'b1 && sclk === 1'b0 && mosi === 1'b0 && cmd_rdy === 1'b1 &&
            read_vld === 1'b0 && read_data === '0)
    else fail_value($sformatf("reset state cs %b sclk %b mosi %b rdy %b vld %b data %h",
                              cs, sclk, mosi, cmd_rdy, read_vld, read_data));
    for (int i = 0; i < num_entries; i++)
      run_entry(i);
    for (int i = 0; i < num_regs; i++)
      assert (slave_regs[i] === ref_regs[i])
      else fail_value($sformatf("slave register %0d holds %h, expected %h",
                                i, slave_regs[i], ref_regs[i]));
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/spi_pkg.sv
logic/spi_cmd_decode.sv
logic/spi_shift_engine.sv
logic/spi_read_capture.sv
logic/spi_cmd_master.sv
dv/spi_cmd_master_assertions.sv
dv/spi_cmd_master_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

top=spi_cmd_master_tb
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f list.f --top-module "$top" -Mdir obj_dir -o "$top"

status=0
"./obj_dir/$top" > "$log" 2>&1 || status=$?
cat "$log"

if grep -q "Test failures found" "$log"; then
  echo "simulation reported failures"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation finished cleanly"
